//--- rtl/timer_pkg.sv
package timer_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int data_w = 32;                 // Bus and counter width
	localparam int num_ch = 3;
	localparam int div_w  = 4;                  // Prescaler divider

	////////////////////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////////////////////

	localparam logic [1:0] addr_ch0  = 2'd0;
	localparam logic [1:0] addr_ch1  = 2'd1;
	localparam logic [1:0] addr_ch2  = 2'd2;
	localparam logic [1:0] addr_ctrl = 2'd3;    // Control on write, status on read

	// Channel modes
	typedef enum logic [1:0] {
		mode_oneshot = 2'b00,
		mode_square  = 2'b01,
		mode_stop    = 2'b10,
		mode_free    = 2'b11
	} mode_t;

	////////////////////////////////////////////////////////////////////////////
	// Control word layout
	////////////////////////////////////////////////////////////////////////////

	localparam int mode_w    = 2;
	localparam int mode_lsb0 = 0;
	localparam int mode_lsb1 = 2;
	localparam int mode_lsb2 = 4;
	localparam int div_lsb0  = 8;
	localparam int div_lsb1  = 12;
	localparam int div_lsb2  = 16;
	localparam int ien_lsb   = 20;              // One enable per channel

	// Bits 7:6 and 31:23 are not implemented
	localparam logic [data_w-1:0] ctrl_mask = 32'h007f_ff3f;

endpackage

//--- rtl/timer_regs.sv
module timer_regs (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              wr,
	input  logic                              rd,
	input  logic [1:0]                        addr,
	input  logic [timer_pkg::data_w-1:0]      wdata,
	input  logic [timer_pkg::data_w-1:0]      count0,
	input  logic [timer_pkg::data_w-1:0]      count1,
	input  logic [timer_pkg::data_w-1:0]      count2,
	input  logic [timer_pkg::num_ch-1:0]      expire,
	output logic [timer_pkg::data_w-1:0]      rdata,
	output logic                              rvalid,
	output logic                              irq,
	output logic [timer_pkg::num_ch-1:0]      load_we,
	output logic [timer_pkg::data_w-1:0]      load_val,
	output timer_pkg::mode_t                  mode0,
	output timer_pkg::mode_t                  mode1,
	output timer_pkg::mode_t                  mode2,
	output logic [timer_pkg::div_w-1:0]       div0,
	output logic [timer_pkg::div_w-1:0]       div1,
	output logic [timer_pkg::div_w-1:0]       div2,
	output logic                              restart
);
	import timer_pkg::*;

	logic              wr_q;
	logic              rd_q;
	logic [1:0]        addr_q;
	logic [data_w-1:0] wdata_q;
	logic [data_w-1:0] ctrl;
	logic [num_ch-1:0] status;          // Sticky expiry flags
	logic              ctrl_we;
	logic              stat_rd;

	////////////////////////////////////////////////////////////////////////////
	// Bus request stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_q   <= 1'b0;
			rd_q   <= 1'b0;
			addr_q <= 2'd0;
		end else begin
			wr_q   <= wr;
			rd_q   <= rd & ~wr;    // Write wins over read
			addr_q <= addr;
		end
	end

	always_ff @(posedge clk) begin
		if (wr)
			wdata_q <= wdata;
	end

	assign ctrl_we = wr_q && (addr_q == addr_ctrl);
	assign stat_rd = rd_q && (addr_q == addr_ctrl);

	// Per-channel load strobes
	assign load_we[0] = wr_q && (addr_q == addr_ch0);
	assign load_we[1] = wr_q && (addr_q == addr_ch1);
	assign load_we[2] = wr_q && (addr_q == addr_ch2);
	assign load_val   = wdata_q;

	////////////////////////////////////////////////////////////////////////////
	// Control word
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl    <= '0;
			restart <= 1'b0;
		end else begin
			restart <= ctrl_we;    // Prescalers reload once the new dividers are visible
			if (ctrl_we)
				ctrl <= wdata_q & ctrl_mask;
		end
	end

	assign mode0 = mode_t'(ctrl[mode_lsb0 +: mode_w]);
	assign mode1 = mode_t'(ctrl[mode_lsb1 +: mode_w]);
	assign mode2 = mode_t'(ctrl[mode_lsb2 +: mode_w]);
	assign div0  = ctrl[div_lsb0 +: div_w];
	assign div1  = ctrl[div_lsb1 +: div_w];
	assign div2  = ctrl[div_lsb2 +: div_w];

	////////////////////////////////////////////////////////////////////////////
	// Status, read data and interrupt
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			status <= '0;
			rvalid <= 1'b0;
			irq    <= 1'b0;
		end else begin
			status <= (stat_rd ? '0 : status) | expire;    // New event beats the clear
			rvalid <= rd_q;
			irq    <= |(status & ctrl[ien_lsb +: num_ch]);
		end
	end

	always_ff @(posedge clk) begin
		if (rd_q) begin
			case (addr_q)
				addr_ch0: rdata <= count0;
				addr_ch1: rdata <= count1;
				addr_ch2: rdata <= count2;
				default:  rdata <= {{(data_w-num_ch){1'b0}}, status};
			endcase
		end
	end

endmodule

//--- rtl/tick_gen.sv
module tick_gen (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [timer_pkg::div_w-1:0]   div,
	input  logic                          restart,
	output logic                          tick
);
	import timer_pkg::*;

	logic [div_w-1:0] cnt;
	logic [div_w-1:0] cnt_cur;

	// A restart acts as if the counter had just been reloaded from div,
	// so the first tick lands div+1 cycles after the control update
	assign cnt_cur = restart ? div : cnt;

	////////////////////////////////////////////////////////////////////////////
	// Prescaler
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else if (cnt_cur == '0) begin
			cnt  <= div;           // Reload for next period
			tick <= 1'b1;
		end else begin
			cnt  <= cnt_cur - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

//--- rtl/count_channel.sv
module count_channel (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          tick,
	input  logic                          load_we,
	input  logic [timer_pkg::data_w-1:0]  load_val,
	input  timer_pkg::mode_t              mode,
	output logic [timer_pkg::data_w-1:0]  count,
	output logic                          out
);
	import timer_pkg::*;

	logic [data_w-1:0] reload;     // Last value written to the channel
	logic              done;       // One-shot has fired

	////////////////////////////////////////////////////////////////////////////
	// Reload register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			reload <= '0;
		else if (load_we)
			reload <= load_val;
	end

	////////////////////////////////////////////////////////////////////////////
	// Counter and output
	////////////////////////////////////////////////////////////////////////////

	// Out of reset the channel counts nothing until it is loaded
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
			out   <= 1'b0;
			done  <= 1'b1;
		end else if (load_we) begin
			count <= load_val;     // Load beats a tick in the same cycle
			out   <= 1'b0;
			done  <= 1'b0;
		end else if (tick) begin
			case (mode)
				mode_oneshot: begin
					if (!done) begin
						if (count != '0) begin
							count <= count - 1'b1;
						end else begin
							out  <= 1'b1;
							done <= 1'b1;
						end
					end
				end
				mode_square: begin
					if (count == '0) begin
						out   <= ~out;
						count <= reload >> 1;    // Half of load for later half-periods
					end else begin
						count <= count - 1'b1;
					end
				end
				mode_free: begin
					count <= count - 1'b1;       // Wraps through all ones
				end
				mode_stop: ;                     // Count and out hold
				default: ;
			endcase
		end
	end

endmodule

//--- rtl/expiry_detect.sv
module expiry_detect (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [timer_pkg::num_ch-1:0]  ch_out,
	output logic [timer_pkg::num_ch-1:0]  expire
);
	import timer_pkg::*;

	logic [num_ch-1:0] out_q;      // Levels seen on the previous edge

	////////////////////////////////////////////////////////////////////////////
	// Rising edge detect
	////////////////////////////////////////////////////////////////////////////

	// Every low to high step counts, so a square wave reports once per period
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_q  <= '0;
			expire <= '0;
		end else begin
			out_q  <= ch_out;
			expire <= ch_out & ~out_q;
		end
	end

endmodule

//--- rtl/timer_top.sv
module timer_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          wr,
	input  logic                          rd,
	input  logic [1:0]                    addr,
	input  logic [timer_pkg::data_w-1:0]  wdata,
	output logic [timer_pkg::data_w-1:0]  rdata,
	output logic                          rvalid,
	output logic                          irq,
	output logic [timer_pkg::num_ch-1:0]  ch_out
);
	import timer_pkg::*;

	logic [num_ch-1:0] load_we;
	logic [data_w-1:0] load_val;
	logic [data_w-1:0] count0;
	logic [data_w-1:0] count1;
	logic [data_w-1:0] count2;
	logic [num_ch-1:0] expire;
	logic [num_ch-1:0] tick;
	logic [div_w-1:0]  div0;
	logic [div_w-1:0]  div1;
	logic [div_w-1:0]  div2;
	logic              restart;
	mode_t             mode0;
	mode_t             mode1;
	mode_t             mode2;

	////////////////////////////////////////////////////////////////////////////
	// Register block
	////////////////////////////////////////////////////////////////////////////

	timer_regs regs0 (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.rd       (rd),
		.addr     (addr),
		.wdata    (wdata),
		.count0   (count0),
		.count1   (count1),
		.count2   (count2),
		.expire   (expire),
		.rdata    (rdata),
		.rvalid   (rvalid),
		.irq      (irq),
		.load_we  (load_we),
		.load_val (load_val),
		.mode0    (mode0),
		.mode1    (mode1),
		.mode2    (mode2),
		.div0     (div0),
		.div1     (div1),
		.div2     (div2),
		.restart  (restart)
	);

	////////////////////////////////////////////////////////////////////////////
	// Channels
	////////////////////////////////////////////////////////////////////////////

	tick_gen tick_gen0 (.clk(clk), .rst(rst), .div(div0), .restart(restart), .tick(tick[0]));
	tick_gen tick_gen1 (.clk(clk), .rst(rst), .div(div1), .restart(restart), .tick(tick[1]));
	tick_gen tick_gen2 (.clk(clk), .rst(rst), .div(div2), .restart(restart), .tick(tick[2]));

	count_channel chan0 (
		.clk(clk), .rst(rst), .tick(tick[0]), .load_we(load_we[0]),
		.load_val(load_val), .mode(mode0), .count(count0), .out(ch_out[0])
	);

	count_channel chan1 (
		.clk(clk), .rst(rst), .tick(tick[1]), .load_we(load_we[1]),
		.load_val(load_val), .mode(mode1), .count(count1), .out(ch_out[1])
	);

	count_channel chan2 (
		.clk(clk), .rst(rst), .tick(tick[2]), .load_we(load_we[2]),
		.load_val(load_val), .mode(mode2), .count(count2), .out(ch_out[2])
	);

	// Expiry events feed the sticky status
	expiry_detect edge0 (
		.clk    (clk),
		.rst    (rst),
		.ch_out (ch_out),
		.expire (expire)
	);

endmodule

//--- testbench/timer_tb_tasks.svh
////////////////////////////////////////////////////////////////////////////
// Bus access and helpers
////////////////////////////////////////////////////////////////////////////

task automatic report_mismatch(
	input string       name,
	input logic [31:0] exp,
	input logic [31:0] act
);
	$display("FAILED at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
	err_count++;
endtask

task automatic end_test(input string name, input int err_start);
	if (err_count == err_start) begin
		tests_passed++;
		$display("%s: passed", name);
	end else begin
		tests_failed++;
		$display("%s: failed with %0d errors", name, err_count - err_start);
	end
endtask

// Modes in 5:0, dividers in 19:8, enables in 22:20
function automatic logic [31:0] make_ctrl(
	input mode_t      m0,
	input mode_t      m1,
	input mode_t      m2,
	input int         d0,
	input int         d1,
	input int         d2,
	input logic [2:0] ien
);
	make_ctrl = {9'd0, ien, d2[3:0], d1[3:0], d0[3:0], 2'b00, m2, m1, m0};
endfunction

task automatic bus_write(input logic [1:0] a, input logic [31:0] d);
	@(posedge clk);
	wr    <= 1'b1;
	addr  <= a;
	wdata <= d;
	@(posedge clk);
	wr    <= 1'b0;            // Returns on the edge that registers the request
endtask

task automatic bus_read(input logic [1:0] a, output logic [31:0] data);
	int n;
	@(posedge clk);
	rd          <= 1'b1;
	addr        <= a;
	last_rd_cyc = cyc;
	@(posedge clk);
	rd <= 1'b0;
	n = 0;
	@(negedge clk);
	while (!rvalid && n < wait_limit) begin
		@(negedge clk);
		n++;
	end
	if (!rvalid) begin
		$display("No read response for address %0d within %0d cycles", a, wait_limit);
		err_count++;
	end
	data = rdata;
endtask

task automatic wait_rise(input logic [1:0] ch, output int stamp);
	logic prev;
	int   n;
	prev  = ch_out[ch];
	n     = 0;
	stamp = -1;
	while (stamp < 0 && n < wait_limit) begin
		@(negedge clk);
		n++;
		if (ch_out[ch] && !prev)
			stamp = cyc;
		prev = ch_out[ch];
	end
	if (stamp < 0) begin
		$display("Channel %0d output did not rise within %0d cycles", ch, wait_limit);
		err_count++;
	end
endtask

task automatic wait_irq(input logic level);
	int n;
	n = 0;
	while (irq !== level && n < wait_limit) begin
		@(negedge clk);
		n++;
	end
	if (irq !== level) begin
		$display("irq did not reach %0d within %0d cycles", level, wait_limit);
		err_count++;
	end
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic reset_values();
	int          err_start;
	int          a;
	logic [31:0] data;
	err_start = err_count;
	@(negedge clk);
	if (irq !== 1'b0)
		report_mismatch("irq", 32'd0, {31'd0, irq});
	if (ch_out !== '0)
		report_mismatch("ch_out", 32'd0, {29'd0, ch_out});
	for (a = 0; a < 4; a++) begin
		bus_read(a[1:0], data);
		if (data !== 32'd0)
			report_mismatch($sformatf("rdata at address %0d", a), 32'd0, data);
	end
	end_test("reset_values", err_start);
endtask

task automatic one_shot_expiry();
	int          err_start;
	int          n;
	int          cycles;
	logic [31:0] rnd;
	logic [31:0] data;
	err_start = err_count;
	rnd = $random(seed);
	n   = 2 + rnd % 19;
	bus_write(addr_ctrl, make_ctrl(mode_oneshot, mode_oneshot, mode_oneshot, 0, 0, 0, 3'b001));
	bus_write(addr_ch0, n);
	cycles = 0;
	while (!ch_out[0] && cycles < wait_limit) begin
		@(negedge clk);
		cycles++;
	end
	// Load lands two edges after the request edge, then N+1 ticks
	if (!ch_out[0]) begin
		$display("Channel 0 did not expire within %0d cycles", wait_limit);
		err_count++;
	end else if (cycles - 2 != n + 1) begin
		report_mismatch("ch_out[0] rise delay", n + 1, cycles - 2);
	end
	wait_irq(1'b1);
	bus_read(addr_ctrl, data);
	if (data !== 32'd1)
		report_mismatch("status", 32'd1, data);
	bus_read(addr_ctrl, data);
	if (data !== 32'd0)
		report_mismatch("status after read", 32'd0, data);
	if (irq !== 1'b0)
		report_mismatch("irq", 32'd0, {31'd0, irq});
	end_test("one_shot_expiry", err_start);
endtask

task automatic square_period();
	int          err_start;
	int          n;
	int          d;
	int          i;
	int          rise;
	int          expected;
	int          stamp[4];
	logic [31:0] rnd;
	err_start = err_count;
	rnd = $random(seed);
	d   = rnd % 4;
	rnd = $random(seed);
	n   = 2 + rnd % 19;
	expected = 2 * (n / 2 + 1) * (d + 1);    // Two half-periods of N/2+1 ticks
	bus_write(addr_ctrl, make_ctrl(mode_oneshot, mode_square, mode_oneshot,
		0, d, 0, 3'b000));
	bus_write(addr_ch1, n);
	// The idle wave may rise once before the load lands
	for (i = 0; i < 4; i++) begin
		wait_rise(2'd1, rise);
		stamp[i] = rise;
	end
	for (i = 2; i < 4; i++) begin
		if (stamp[i] - stamp[i-1] != expected)
			report_mismatch("ch_out[1] period", expected, stamp[i] - stamp[i-1]);
	end
	end_test("square_period", err_start);
endtask

task automatic stop_and_free_run();
	int          err_start;
	int          start;
	int          k;
	logic [31:0] rnd;
	logic [31:0] v;
	logic [31:0] first;
	logic [31:0] second;
	err_start = err_count;
	rnd = $random(seed);
	v   = 100 + rnd % 1000;
	bus_write(addr_ctrl, make_ctrl(mode_oneshot, mode_stop, mode_stop, 0, 0, 0, 3'b000));
	bus_write(addr_ch2, v);
	bus_read(addr_ch2, first);
	rnd = $random(seed);
	repeat (3 + rnd % 10) @(negedge clk);
	bus_read(addr_ch2, second);
	if (first !== v)
		report_mismatch("count2 in stop mode", v, first);
	if (second !== v)
		report_mismatch("count2 later in stop mode", v, second);

	bus_write(addr_ctrl, make_ctrl(mode_oneshot, mode_stop, mode_free, 0, 0, 0, 3'b000));
	bus_read(addr_ch2, first);
	start = last_rd_cyc;
	rnd = $random(seed);
	repeat (3 + rnd % 10) @(negedge clk);
	bus_read(addr_ch2, second);
	k = last_rd_cyc - start;               // One tick per cycle with divider 0
	if (first - second !== k)
		report_mismatch("count2 decrement over K cycles", k, first - second);

	bus_write(addr_ch2, 32'd1);
	@(posedge clk);                        // Two ticks pass before the sampled count
	bus_read(addr_ch2, first);
	if (first !== 32'hffff_ffff)
		report_mismatch("count2 after wrap", 32'hffff_ffff, first);
	end_test("stop_and_free_run", err_start);
endtask

task automatic irq_masking();
	int          err_start;
	int          n;
	int          rise;
	logic        raised;
	logic [31:0] rnd;
	logic [31:0] data;
	err_start = err_count;
	bus_write(addr_ctrl, make_ctrl(mode_oneshot, mode_stop, mode_stop, 0, 0, 0, 3'b000));
	bus_read(addr_ctrl, data);             // Drop flags left by earlier tests
	rnd = $random(seed);
	n   = 2 + rnd % 10;
	bus_write(addr_ch0, n);
	wait_rise(2'd0, rise);
	raised = 1'b0;
	repeat (16) begin
		@(negedge clk);
		if (irq)
			raised = 1'b1;
	end
	if (raised)
		report_mismatch("irq with enable clear", 32'd0, 32'd1);
	bus_write(addr_ctrl, make_ctrl(mode_oneshot, mode_stop, mode_stop, 0, 0, 0, 3'b001));
	wait_irq(1'b1);                        // Status is still set from the expiry
	bus_read(addr_ctrl, data);
	if (data[0] !== 1'b1)
		report_mismatch("status[0]", 32'd1, {31'd0, data[0]});
	wait_irq(1'b0);
	end_test("irq_masking", err_start);
endtask

//--- testbench/timer_tb.sv
module timer_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import timer_pkg::*;

	localparam int wait_limit = 1000;     // Cycles any single wait may take

	logic              clk = 1'b0;
	logic              rst;
	logic              wr;
	logic              rd;
	logic [1:0]        addr;
	logic [data_w-1:0] wdata;
	logic [data_w-1:0] rdata;
	logic              rvalid;
	logic              irq;
	logic [num_ch-1:0] ch_out;

	int seed;
	int cyc = 0;            // Rising edges seen so far
	int last_rd_cyc;        // Edge on which the last read was issued
	int err_count;
	int tests_passed;
	int tests_failed;

	////////////////////////////////////////////////////////////////////////////
	// DUT, clock and watchdog
	////////////////////////////////////////////////////////////////////////////

	timer_top dut0 (
		.clk    (clk),
		.rst    (rst),
		.wr     (wr),
		.rd     (rd),
		.addr   (addr),
		.wdata  (wdata),
		.rdata  (rdata),
		.rvalid (rvalid),
		.irq    (irq),
		.ch_out (ch_out)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// Last resort in case a wait loop itself misbehaves
	initial begin
		#400_000;
		$display("Watchdog expired before the test sequence finished");
		$display("sim failed");
		$finish;
	end

	`include "timer_tb_tasks.svh"

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed         = 32'hdb03;
		err_count    = 0;
		tests_passed = 0;
		tests_failed = 0;
		rst          = 1'b1;
		wr           = 1'b0;
		rd           = 1'b0;
		addr         = 2'd0;
		wdata        = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		reset_values();
		one_shot_expiry();
		square_period();
		stop_and_free_run();
		irq_masking();

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (err_count == 0 && tests_failed == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- build.f
+incdir+testbench
rtl/timer_pkg.sv
rtl/timer_regs.sv
rtl/tick_gen.sv
rtl/count_channel.sv
rtl/expiry_detect.sv
rtl/timer_top.sv
testbench/timer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the timer testbench with Verilator and runs it, the log decides the result

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module timer_tb \
	-o timer_sim > "$log" 2>&1 &&
	./obj_dir/timer_sim >> "$log" 2>&1 ||
	echo "sim failed" >> "$log"

grep -q "sim failed" "$log" && echo "FAIL, see $log" && exit 1
echo "PASS"
exit 0
